/* hw/decode_pkg.sv */
/*
 * Decoder-side types seen by the branch unit.
 * The resolution logic imports these to read the decoded instruction.
 */
package decode_pkg;

	// Branch kind produced by the decoder
	typedef enum logic [1:0] {
		branch_invalid   = 2'd0,
		branch_immediate = 2'd1,
		branch_indirect  = 2'd2,
		branch_condition = 2'd3
	} branch_type_t;

	// Compare for conditional branches, rj against rd
	typedef enum logic [2:0] {
		cmp_eql = 3'd0,
		cmp_neq = 3'd1,
		cmp_lss = 3'd2,
		cmp_ger = 3'd3,
		cmp_leq = 3'd4,
		cmp_geq = 3'd5,
		cmp_ltu = 3'd6,
		cmp_geu = 3'd7
	} cmp_type_t;

	// Decoded fields that reach execute
	typedef struct packed {
		logic [25:0]  inst25_0;
		branch_type_t branch_type;
		cmp_type_t    cmp_type;
		logic         branch_link;
		logic         valid;
	} decode_info_t;

endpackage

/* hw/bpu_pkg.sv */
/*
 * Predictor-side types: word addresses, branch classes and the records
 * passed from fetch to execute and from resolution back to the tables.
 */
package bpu_pkg;

	// --------------------
	// Widths
	// --------------------
	parameter int WORD_ADDR_W = 30;

	// Fixed room in the records, module parameters must fit inside
	parameter int HIST_MAX_W    = 6;
	parameter int LHT_IDX_MAX_W = 8;

	// PC without the byte offset
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;

	typedef logic [HIST_MAX_W-1:0]    lphr_t;
	typedef logic [LHT_IDX_MAX_W-1:0] lphr_index_t;

	// Branch class kept in the BTB
	typedef enum logic [1:0] {
		br_pc_relative = 2'd0,
		br_absolute    = 2'd1,
		br_call        = 2'd2,
		br_return      = 2'd3
	} br_class_t;

	// --------------------
	// Records
	// --------------------

	// Travels with the fetched instruction down to execute
	typedef struct packed {
		word_addr_t  npc;
		lphr_t       lphr;
		lphr_index_t lphr_index;
	} bpu_predict_t;

	// Built at resolution, written into the tables on the next edge
	typedef struct packed {
		word_addr_t  pc;
		word_addr_t  br_target;
		logic        br_taken;
		logic        flush;
		logic        btb_update;
		logic        bht_update;
		logic        lpht_update;
		br_class_t   br_type;
		lphr_t       lphr;
		lphr_index_t lphr_index;
	} bpu_update_t;

endpackage

/* hw/bpu_btb.sv */
/*
 * Direct-mapped branch target buffer.
 * Combinational lookup by fetch PC, whole-entry write on resolution.
 */
`timescale 1ns/1ps

module bpu_btb #(
	parameter int BTB_IDX_W = 6
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  bpu_pkg::word_addr_t  rd_pc_i,
	output logic                 hit_o,
	output bpu_pkg::word_addr_t  rd_target_o,
	output bpu_pkg::br_class_t   rd_class_o,
	input  bpu_pkg::bpu_update_t update_i
);
	import bpu_pkg::*;

	localparam int TAG_W   = WORD_ADDR_W - BTB_IDX_W;
	localparam int ENTRIES = 1 << BTB_IDX_W;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		word_addr_t       target;
		br_class_t        cls;
	} btb_entry_t;

	logic [ENTRIES-1:0] valid_q;
	btb_entry_t         entry_q [ENTRIES];

	logic [BTB_IDX_W-1:0] rd_idx;
	logic [BTB_IDX_W-1:0] wr_idx;
	logic [TAG_W-1:0]     rd_tag;
	logic [TAG_W-1:0]     wr_tag;
	btb_entry_t           rd_entry;

	// Index from the low bits, tag from the rest
	assign rd_idx = rd_pc_i[BTB_IDX_W-1:0];
	assign rd_tag = rd_pc_i[WORD_ADDR_W-1:BTB_IDX_W];
	assign wr_idx = update_i.pc[BTB_IDX_W-1:0];
	assign wr_tag = update_i.pc[WORD_ADDR_W-1:BTB_IDX_W];

	assign rd_entry    = entry_q[rd_idx];
	assign hit_o       = valid_q[rd_idx] && (rd_entry.tag == rd_tag);
	assign rd_target_o = rd_entry.target;
	assign rd_class_o  = rd_entry.cls;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else if (update_i.btb_update) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	// Replace the whole entry
	always_ff @(posedge clk) begin
		if (update_i.btb_update) begin
			entry_q[wr_idx] <= '{tag: wr_tag, target: update_i.br_target, cls: update_i.br_type};
		end
	end

endmodule

/* hw/bpu_lpht.sv */
/*
 * Local history predictor: one history per PC index and a table of
 * two-bit counters indexed by history xor PC.
 */
`timescale 1ns/1ps

module bpu_lpht #(
	parameter int HIST_W    = 4,
	parameter int LHT_IDX_W = 6
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  bpu_pkg::word_addr_t  rd_pc_i,
	output logic                 taken_o,
	output logic [HIST_W-1:0]    lphr_o,
	output logic [LHT_IDX_W-1:0] lphr_index_o,
	input  bpu_pkg::bpu_update_t update_i
);
	localparam int LHT_ENTRIES = 1 << LHT_IDX_W;
	localparam int PHT_ENTRIES = 1 << HIST_W;

	logic [HIST_W-1:0] lhr_q [LHT_ENTRIES];
	logic [1:0]        pht_q [PHT_ENTRIES];

	logic [HIST_W-1:0]    pht_rd_idx;
	logic [HIST_W-1:0]    pht_wr_idx;
	logic [HIST_W-1:0]    upd_lphr;
	logic [LHT_IDX_W-1:0] upd_idx;
	logic [1:0]           ctr_old;
	logic [1:0]           ctr_new;

	// --------------------
	// Lookup
	// --------------------
	assign lphr_index_o = rd_pc_i[LHT_IDX_W-1:0];
	assign lphr_o       = lhr_q[lphr_index_o];
	assign pht_rd_idx   = lphr_o ^ rd_pc_i[HIST_W-1:0];
	assign taken_o      = pht_q[pht_rd_idx][1];

	// --------------------
	// Update
	// --------------------
	// History carried with the branch, not the current table value
	assign upd_lphr   = update_i.lphr[HIST_W-1:0];
	assign upd_idx    = update_i.lphr_index[LHT_IDX_W-1:0];
	assign pht_wr_idx = upd_lphr ^ update_i.pc[HIST_W-1:0];
	assign ctr_old    = pht_q[pht_wr_idx];

	// Saturating step
	always_comb begin
		if (update_i.br_taken) begin
			ctr_new = (ctr_old == 2'b11) ? 2'b11 : ctr_old + 2'd1;
		end else begin
			ctr_new = (ctr_old == 2'b00) ? 2'b00 : ctr_old - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < LHT_ENTRIES; i++) begin
				lhr_q[i] <= '0;
			end
			// Weakly not taken
			for (int j = 0; j < PHT_ENTRIES; j++) begin
				pht_q[j] <= 2'b01;
			end
		end else if (update_i.lpht_update) begin
			lhr_q[upd_idx]    <= {upd_lphr[HIST_W-2:0], update_i.br_taken};
			pht_q[pht_wr_idx] <= ctr_new;
		end
	end

endmodule

/* hw/bpu_ras.sv */
/*
 * Return address stack, circular, updated only at resolution.
 * Calls push the return word address, returns pop it.
 */
`timescale 1ns/1ps

module bpu_ras #(
	parameter int RAS_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  bpu_pkg::bpu_update_t update_i,
	output logic                 top_valid_o,
	output bpu_pkg::word_addr_t  top_o
);
	import bpu_pkg::*;

	localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
	localparam int CNT_W = $clog2(RAS_DEPTH + 1);

	word_addr_t        stack_q [RAS_DEPTH];
	logic [PTR_W-1:0]  top_q;
	logic [CNT_W-1:0]  count_q;
	logic [PTR_W-1:0]  top_inc;
	logic [PTR_W-1:0]  top_dec;
	logic              push;
	logic              pop;

	assign push = update_i.bht_update && (update_i.br_type == br_call);
	assign pop  = update_i.bht_update && (update_i.br_type == br_return);

	// Wrap for any depth
	assign top_inc = (top_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : top_q + 1'b1;
	assign top_dec = (top_q == '0) ? PTR_W'(RAS_DEPTH - 1) : top_q - 1'b1;

	assign top_valid_o = (count_q != '0);
	assign top_o       = stack_q[top_q];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			top_q   <= '0;
			count_q <= '0;
		end else if (push) begin
			top_q <= top_inc;
			// Full stack drops the oldest entry
			if (count_q != CNT_W'(RAS_DEPTH)) begin
				count_q <= count_q + 1'b1;
			end
		end else if (pop && count_q != '0) begin
			top_q   <= top_dec;
			count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			stack_q[top_inc] <= update_i.pc + 30'd1;
		end
	end

endmodule

/* hw/bpu_predict.sv */
/*
 * Next fetch address from the BTB, pattern and RAS lookups.
 * Purely combinational, used in the fetch cycle.
 */
`timescale 1ns/1ps

module bpu_predict #(
	parameter int HIST_W    = 4,
	parameter int LHT_IDX_W = 6
) (
	input  logic [31:0]           fetch_pc_i,
	input  logic                  btb_hit_i,
	input  bpu_pkg::word_addr_t   btb_target_i,
	input  bpu_pkg::br_class_t    btb_class_i,
	input  logic                  lpht_taken_i,
	input  logic [HIST_W-1:0]     lphr_i,
	input  logic [LHT_IDX_W-1:0]  lphr_index_i,
	input  logic                  ras_valid_i,
	input  bpu_pkg::word_addr_t   ras_top_i,
	output bpu_pkg::word_addr_t   rd_pc_o,
	output bpu_pkg::bpu_predict_t predict_o
);
	import bpu_pkg::*;

	word_addr_t seq_pc;
	word_addr_t npc;

	assign rd_pc_o = fetch_pc_i[31:2];
	assign seq_pc  = rd_pc_o + 30'd1;

	// Fall through unless the BTB knows better
	always_comb begin
		npc = seq_pc;
		if (btb_hit_i) begin
			case (btb_class_i)
				br_return: begin
					if (ras_valid_i) begin
						npc = ras_top_i;
					end
				end
				br_absolute, br_call: npc = btb_target_i;
				default: begin
					if (lpht_taken_i) begin
						npc = btb_target_i;
					end
				end
			endcase
		end
	end

	always_comb begin
		predict_o                             = '0;
		predict_o.npc                         = npc;
		predict_o.lphr[HIST_W-1:0]            = lphr_i;
		predict_o.lphr_index[LHT_IDX_W-1:0]   = lphr_index_i;
	end

endmodule

/* hw/bpf.sv */
/*
 * Branch resolution at execute. Works out the real target, direction,
 * class and link address, and builds the update record for the tables.
 */
`timescale 1ns/1ps

module bpf (
	input  decode_pkg::decode_info_t decode_i,
	input  logic [31:0]              pc_i,
	input  logic [31:0]              rj_i,
	input  logic [31:0]              rd_i,
	input  bpu_pkg::bpu_predict_t    predict_i,
	output bpu_pkg::bpu_update_t     update_o,
	output logic [31:0]              pc_link_o
);
	import decode_pkg::*;
	import bpu_pkg::*;

	logic [25:0]  offs;
	logic [4:0]   rj_idx;
	logic [4:0]   rd_idx;
	logic [31:0]  offs_26;
	logic [31:0]  offs_16;
	logic [31:0]  target;
	logic         taken;
	logic         is_branch;
	branch_type_t br_kind;
	br_class_t    br_class;

	assign offs      = decode_i.inst25_0;
	assign rj_idx    = offs[9:5];
	assign rd_idx    = offs[4:0];
	assign br_kind   = decode_i.branch_type;
	assign is_branch = (br_kind != branch_invalid);

	// Offsets in words, sign extended
	assign offs_26 = {{6{offs[25]}}, offs};
	assign offs_16 = {{16{offs[25]}}, offs[25:10]};

	// --------------------
	// Target and direction
	// --------------------
	always_comb begin
		case (br_kind)
			branch_immediate: target = pc_i + (offs_26 << 2);
			branch_indirect:  target = rj_i + (offs_16 << 2);
			branch_condition: target = pc_i + (offs_16 << 2);
			default:          target = pc_i + 32'd4;
		endcase
	end

	always_comb begin
		if (br_kind == branch_condition) begin
			case (decode_i.cmp_type)
				cmp_eql: taken = (rj_i == rd_i);
				cmp_neq: taken = (rj_i != rd_i);
				cmp_lss: taken = ($signed(rj_i) < $signed(rd_i));
				cmp_ger: taken = ($signed(rj_i) > $signed(rd_i));
				cmp_leq: taken = ($signed(rj_i) <= $signed(rd_i));
				cmp_geq: taken = ($signed(rj_i) >= $signed(rd_i));
				cmp_ltu: taken = (rj_i < rd_i);
				default: taken = (rj_i >= rd_i);
			endcase
		end else begin
			taken = is_branch;
		end
	end

	// --------------------
	// Class
	// --------------------
	always_comb begin
		if ((br_kind == branch_indirect && rd_idx == 5'd1) || decode_i.branch_link) begin
			br_class = br_call;
		end else if (br_kind == branch_indirect && rj_idx == 5'd1 && offs_16 == '0) begin
			br_class = br_return;
		end else if (br_kind == branch_immediate || br_kind == branch_indirect) begin
			br_class = br_absolute;
		end else begin
			br_class = br_pc_relative;
		end
	end

	assign pc_link_o = pc_i + 32'd4;

	// Update record
	always_comb begin
		update_o             = '0;
		update_o.pc          = pc_i[31:2];
		update_o.br_target   = target[31:2];
		update_o.br_taken    = taken;
		update_o.flush       = (predict_i.npc != target[31:2]) && decode_i.valid;
		update_o.btb_update  = update_o.flush;
		update_o.bht_update  = is_branch;
		update_o.lpht_update = is_branch;
		update_o.br_type     = br_class;
		update_o.lphr        = predict_i.lphr;
		update_o.lphr_index  = predict_i.lphr_index;
	end

endmodule

/* hw/bpu_top.sv */
/*
 * Branch prediction unit top. Fetch-side prediction, execute-side
 * resolution, and the BTB, pattern and RAS tables they share.
 */
`timescale 1ns/1ps

module bpu_top #(
	parameter int BTB_IDX_W = 6,
	parameter int LHT_IDX_W = 6,
	parameter int HIST_W    = 4,
	parameter int RAS_DEPTH = 8
) (
	input  logic                     clk,
	input  logic                     rst_n_i,
	// Fetch side
	input  logic [31:0]              fetch_pc_i,
	output bpu_pkg::bpu_predict_t    predict_o,
	// Resolve side
	input  logic [31:0]              ex_pc_i,
	input  logic [31:0]              rj_i,
	input  logic [31:0]              rd_i,
	input  decode_pkg::decode_info_t decode_i,
	input  bpu_pkg::bpu_predict_t    ex_predict_i,
	output bpu_pkg::bpu_update_t     update_o,
	output logic [31:0]              pc_link_o
);
	import bpu_pkg::*;

	word_addr_t           rd_pc;
	logic                 btb_hit;
	word_addr_t           btb_target;
	br_class_t            btb_class;
	logic                 lpht_taken;
	logic [HIST_W-1:0]    lphr;
	logic [LHT_IDX_W-1:0] lphr_index;
	logic                 ras_valid;
	word_addr_t           ras_top;

	bpu_predict #(.HIST_W(HIST_W), .LHT_IDX_W(LHT_IDX_W)) u_predict (
		.fetch_pc_i(fetch_pc_i), .btb_hit_i(btb_hit), .btb_target_i(btb_target),
		.btb_class_i(btb_class), .lpht_taken_i(lpht_taken), .lphr_i(lphr),
		.lphr_index_i(lphr_index), .ras_valid_i(ras_valid), .ras_top_i(ras_top),
		.rd_pc_o(rd_pc), .predict_o(predict_o)
	);

	bpu_btb #(.BTB_IDX_W(BTB_IDX_W)) u_btb (
		.clk(clk), .rst_n_i(rst_n_i), .rd_pc_i(rd_pc), .hit_o(btb_hit),
		.rd_target_o(btb_target), .rd_class_o(btb_class), .update_i(update_o)
	);

	bpu_lpht #(.HIST_W(HIST_W), .LHT_IDX_W(LHT_IDX_W)) u_lpht (
		.clk(clk), .rst_n_i(rst_n_i), .rd_pc_i(rd_pc), .taken_o(lpht_taken),
		.lphr_o(lphr), .lphr_index_o(lphr_index), .update_i(update_o)
	);

	bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
		.clk(clk), .rst_n_i(rst_n_i), .update_i(update_o),
		.top_valid_o(ras_valid), .top_o(ras_top)
	);

	bpf u_bpf (
		.decode_i(decode_i), .pc_i(ex_pc_i), .rj_i(rj_i), .rd_i(rd_i),
		.predict_i(ex_predict_i), .update_o(update_o), .pc_link_o(pc_link_o)
	);

endmodule

/* verif/bpu_tb.sv */
/*
 * Testbench for the branch prediction unit. Replays the golden vectors,
 * one per cycle: fetch and resolve inputs on the falling edge, checks
 * of prediction and update outputs just before the next rising edge.
 */
`timescale 1ns/1ps

module bpu_tb;
	import decode_pkg::*;
	import bpu_pkg::*;

	localparam int    CLK_PERIOD  = 100;
	localparam int    CHECK_DELAY = 40;
	localparam string GOLDEN_PATH = "verif/bpu_golden.txt";

	// Defaults of the DUT
	localparam int HIST_W    = 4;
	localparam int LHT_IDX_W = 6;

	// One line of the golden file
	typedef struct packed {
		logic [31:0] fetch_pc;
		logic [31:0] ex_pc;
		logic [31:0] rj;
		logic [31:0] rd;
		logic [25:0] inst;
		logic [1:0]  btype;
		logic [2:0]  cmp;
		logic        link;
		logic        valid;
		word_addr_t  ex_npc;
		lphr_t       ex_lphr;
		lphr_index_t ex_idx;
		word_addr_t  exp_npc;
		word_addr_t  exp_target;
		logic        exp_taken;
		logic        exp_flush;
		logic [1:0]  exp_type;
		logic [31:0] exp_link;
	} golden_vec_t;

	logic         clk = 1'b0;
	logic         rst_n_i;
	logic [31:0]  fetch_pc_i;
	bpu_predict_t predict_o;
	logic [31:0]  ex_pc_i;
	logic [31:0]  rj_i;
	logic [31:0]  rd_i;
	decode_info_t decode_i;
	bpu_predict_t ex_predict_i;
	bpu_update_t  update_o;
	logic [31:0]  pc_link_o;

	golden_vec_t vecs[$];
	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 20;

	// Expected local histories, one per history index
	logic [HIST_W-1:0] hist_model [1 << LHT_IDX_W];

	bpu_top DUT (
		.clk(clk), .rst_n_i(rst_n_i), .fetch_pc_i(fetch_pc_i), .predict_o(predict_o),
		.ex_pc_i(ex_pc_i), .rj_i(rj_i), .rd_i(rd_i), .decode_i(decode_i),
		.ex_predict_i(ex_predict_i), .update_o(update_o), .pc_link_o(pc_link_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Run limit, set once the vectors are loaded
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: run did not end within %0d cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// --------------------
	// Vector file
	// --------------------
	task automatic load_golden();
		int          fd;
		int          cnt;
		string       line;
		golden_vec_t v;
		logic [31:0] f_pc, e_pc, rj, rd;
		logic [31:0] inst, btype, cmp, link, valid;
		logic [31:0] e_npc, e_lphr, e_idx;
		logic [31:0] x_npc, x_tgt, x_taken, x_flush, x_type, x_link;
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0) begin
			$display("Cannot open the golden file %s", GOLDEN_PATH);
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			cnt = $fgets(line, fd);
			// Skip blank and comment lines
			if (cnt > 0 && line.len() > 1 && line.getc(0) != "#") begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f_pc, e_pc, rj, rd, inst, btype, cmp, link, valid,
					e_npc, e_lphr, e_idx, x_npc, x_tgt, x_taken, x_flush, x_type, x_link);
				if (cnt != 18) begin
					$display("Golden line with %0d fields instead of 18: %s", cnt, line);
					errors++;
				end else begin
					v.fetch_pc   = f_pc;
					v.ex_pc      = e_pc;
					v.rj         = rj;
					v.rd         = rd;
					v.inst       = inst[25:0];
					v.btype      = btype[1:0];
					v.cmp        = cmp[2:0];
					v.link       = link[0];
					v.valid      = valid[0];
					v.ex_npc     = e_npc[WORD_ADDR_W-1:0];
					v.ex_lphr    = e_lphr[HIST_MAX_W-1:0];
					v.ex_idx     = e_idx[LHT_IDX_MAX_W-1:0];
					v.exp_npc    = x_npc[WORD_ADDR_W-1:0];
					v.exp_target = x_tgt[WORD_ADDR_W-1:0];
					v.exp_taken  = x_taken[0];
					v.exp_flush  = x_flush[0];
					v.exp_type   = x_type[1:0];
					v.exp_link   = x_link;
					vecs.push_back(v);
				end
			end
		end
		$fclose(fd);
	endtask

	// --------------------
	// Drive and compare
	// --------------------
	task automatic apply_vector(input golden_vec_t v);
		fetch_pc_i              = v.fetch_pc;
		ex_pc_i                 = v.ex_pc;
		rj_i                    = v.rj;
		rd_i                    = v.rd;
		decode_i.inst25_0       = v.inst;
		decode_i.branch_type    = branch_type_t'(v.btype);
		decode_i.cmp_type       = cmp_type_t'(v.cmp);
		decode_i.branch_link    = v.link;
		decode_i.valid          = v.valid;
		ex_predict_i.npc        = v.ex_npc;
		ex_predict_i.lphr       = v.ex_lphr;
		ex_predict_i.lphr_index = v.ex_idx;
	endtask

	// Every branch kind shifts its outcome into the history it carried
	task automatic record_history(input golden_vec_t v);
		lphr_index_t slot;
		slot = v.ex_idx;
		if (v.btype != 2'd0) begin
			hist_model[slot[LHT_IDX_W-1:0]] = {v.ex_lphr[HIST_W-2:0], v.exp_taken};
		end
	endtask

	task automatic check_vector(input int idx, input golden_vec_t v);
		lphr_index_t exp_hist_idx;
		lphr_t       exp_hist;
		logic        exp_upd;
		exp_hist_idx = lphr_index_t'(v.fetch_pc[LHT_IDX_W+1:2]);
		exp_hist     = lphr_t'(hist_model[exp_hist_idx[LHT_IDX_W-1:0]]);
		exp_upd      = (v.btype != 2'd0);
		checks += 14;
		if (predict_o.npc !== v.exp_npc) begin
			$display("MISMATCH predict_o.npc vector %0d: got %h, expected %h",
				idx, predict_o.npc, v.exp_npc);
			errors++;
		end
		if (predict_o.lphr !== exp_hist) begin
			$display("MISMATCH predict_o.lphr vector %0d: got %h, expected %h",
				idx, predict_o.lphr, exp_hist);
			errors++;
		end
		if (predict_o.lphr_index !== exp_hist_idx) begin
			$display("MISMATCH predict_o.lphr_index vector %0d: got %h, expected %h",
				idx, predict_o.lphr_index, exp_hist_idx);
			errors++;
		end
		if (update_o.pc !== v.ex_pc[31:2]) begin
			$display("MISMATCH update_o.pc vector %0d: got %h, expected %h",
				idx, update_o.pc, v.ex_pc[31:2]);
			errors++;
		end
		if (update_o.br_target !== v.exp_target) begin
			$display("MISMATCH update_o.br_target vector %0d: got %h, expected %h",
				idx, update_o.br_target, v.exp_target);
			errors++;
		end
		if (update_o.br_taken !== v.exp_taken) begin
			$display("MISMATCH update_o.br_taken vector %0d: got %h, expected %h",
				idx, update_o.br_taken, v.exp_taken);
			errors++;
		end
		if (update_o.flush !== v.exp_flush) begin
			$display("MISMATCH update_o.flush vector %0d: got %h, expected %h",
				idx, update_o.flush, v.exp_flush);
			errors++;
		end
		if (update_o.btb_update !== v.exp_flush) begin
			$display("MISMATCH update_o.btb_update vector %0d: got %h, expected %h",
				idx, update_o.btb_update, v.exp_flush);
			errors++;
		end
		if (update_o.bht_update !== exp_upd) begin
			$display("MISMATCH update_o.bht_update vector %0d: got %h, expected %h",
				idx, update_o.bht_update, exp_upd);
			errors++;
		end
		if (update_o.lpht_update !== exp_upd) begin
			$display("MISMATCH update_o.lpht_update vector %0d: got %h, expected %h",
				idx, update_o.lpht_update, exp_upd);
			errors++;
		end
		if (update_o.br_type !== br_class_t'(v.exp_type)) begin
			$display("MISMATCH update_o.br_type vector %0d: got %h, expected %h",
				idx, update_o.br_type, v.exp_type);
			errors++;
		end
		if (update_o.lphr !== v.ex_lphr) begin
			$display("MISMATCH update_o.lphr vector %0d: got %h, expected %h",
				idx, update_o.lphr, v.ex_lphr);
			errors++;
		end
		if (update_o.lphr_index !== v.ex_idx) begin
			$display("MISMATCH update_o.lphr_index vector %0d: got %h, expected %h",
				idx, update_o.lphr_index, v.ex_idx);
			errors++;
		end
		if (pc_link_o !== v.exp_link) begin
			$display("MISMATCH pc_link_o vector %0d: got %h, expected %h",
				idx, pc_link_o, v.exp_link);
			errors++;
		end
	endtask

	initial begin
		rst_n_i      = 1'b0;
		fetch_pc_i   = '0;
		ex_pc_i      = '0;
		rj_i         = '0;
		rd_i         = '0;
		decode_i     = '0;
		ex_predict_i = '0;
		foreach (hist_model[k]) begin
			hist_model[k] = '0;
		end
		load_golden();
		cycle_limit = vecs.size() + 20;
		if (vecs.size() == 0) begin
			$display("No vectors were loaded from the golden file");
			errors++;
		end

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;

		// Tables written at a rising edge show up in the next vector's fetch
		for (int i = 0; i < vecs.size(); i++) begin
			apply_vector(vecs[i]);
			#(CHECK_DELAY);
			check_vector(i, vecs[i]);
			record_history(vecs[i]);
			@(negedge clk);
		end

		$display("Vectors: %0d, checks: %0d, errors: %0d", vecs.size(), checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
hw/decode_pkg.sv
hw/bpu_pkg.sv
hw/bpu_btb.sv
hw/bpu_lpht.sv
hw/bpu_ras.sv
hw/bpu_predict.sv
hw/bpf.sv
hw/bpu_top.sv
verif/bpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the branch unit testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f src.f --top-module bpu_tb -o bpu_sim > build.log 2>&1 &&
	./obj_dir/bpu_sim > sim.log 2>&1 ||
	{ echo "Build or run error, see build.log and sim.log"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported errors, see sim.log"; exit 1; }
echo "Simulation finished, no failure found in sim.log"
exit 0

/* verif/bpu_golden.txt */
# fetch_pc ex_pc rj rd inst25_0 branch_type cmp_type link valid ex_npc ex_lphr ex_lphr_index
# then expected: npc br_target br_taken flush br_type pc_link (npc, ex_npc, br_target are words)
00004000 00010000 00000000 00000000 0000100 1 0 0 1 4001 0 3f 1001 4100 1 1 1 00010004
00010000 00010004 00000000 00000000 3fffffc 1 0 0 1 3ffd 0 3f 4100 3ffd 1 0 1 00010008
00004008 00010008 00020000 00000000 00020a0 2 0 0 1 8008 0 3f 1003 8008 1 0 1 0001000c
0000400c 0001000c 00030000 00000000 3fff843 2 0 0 1 4004 0 3f 1004 bffe 1 1 1 00010010
00004010 00010010 00000005 00000005 3fff000 3 0 0 1 4000 0 3f 1005 4000 1 0 0 00010014
00004014 00010014 00000000 00000000 0001234 0 0 0 1 4006 0 3f 1006 4006 0 0 0 00010018
00004018 00010040 80000000 00000001 0001000 3 0 0 1 4014 0 3f 1007 4014 0 0 0 00010044
0000401c 00010044 80000000 00000001 0001000 3 1 0 1 4015 0 3f 1008 4015 1 0 0 00010048
00004020 00010048 80000000 00000001 0001000 3 2 0 1 4016 0 3f 1009 4016 1 0 0 0001004c
00004024 0001004c 80000000 00000001 0001000 3 3 0 1 4017 0 3f 100a 4017 0 0 0 00010050
00004028 00010050 80000000 00000001 0001000 3 4 0 1 4018 0 3f 100b 4018 1 0 0 00010054
0000402c 00010054 80000000 00000001 0001000 3 5 0 1 4019 0 3f 100c 4019 0 0 0 00010058
00004030 00010058 80000000 00000001 0001000 3 6 0 1 401a 0 3f 100d 401a 0 0 0 0001005c
00004034 0001005c 80000000 00000001 0001000 3 7 0 1 401b 0 3f 100e 401b 1 0 0 00010060
000100a0 000100a0 00000007 00000007 0004000 3 0 0 1 4029 0 3f 4029 4038 1 1 0 000100a4
0000403c 000100a0 00000007 00000007 0004000 3 0 0 0 4029 0 3f 1010 4038 1 0 0 000100a4
000100a0 00010104 00012340 00000000 0000020 2 0 0 1 4042 0 3f 4038 48d0 1 1 3 00010108
00010104 00010200 00000000 00000000 0000040 1 0 1 1 40c0 0 3f 4042 40c0 1 0 2 00010204
00010104 00010300 00014000 00000000 0000061 2 0 0 1 5000 0 3f 4081 5000 1 0 2 00010304
00010104 00010400 00010304 00000000 0000020 2 0 0 1 40c1 0 3f 40c1 40c1 1 0 3 00010404
00010104 00010500 00010204 00000000 0001020 2 0 0 1 4085 0 3f 4081 4085 1 0 1 00010504
00010104 00010614 00000001 80000000 0002000 3 2 0 1 4186 0 3f 4081 418d 0 1 0 00010618
00010614 00010700 00000001 80000000 0000800 3 6 0 1 41c2 0 3f 4186 41c2 1 0 0 00010704
00010000 00010800 00011000 00000000 0000021 2 0 0 0 0 0 3f 4100 4400 1 0 2 00010804
00010104 00010900 00000000 00000000 0000000 0 0 0 0 0 0 3f 4201 4241 0 0 0 00010904
0001000c 00010a00 00000000 00000000 0000000 0 0 0 1 4281 0 3f bffe 4281 0 0 0 00010a04
